// File: source/rooth_pkg.sv
// rooth bus package with word width, slave address map and register offsets
`default_nettype none

package rooth_pkg;

    // ----------------------------------------
    // bus word
    // ----------------------------------------
    localparam int CPU_WIDTH = 32;

    // ----------------------------------------
    // slave map, address bits 31..28
    // ----------------------------------------
    localparam int SLV_SEL_W = 4;
    localparam logic [SLV_SEL_W-1:0] SLV_RAM   = 4'h0;
    localparam logic [SLV_SEL_W-1:0] SLV_TIMER = 4'h1;
    localparam logic [SLV_SEL_W-1:0] SLV_GPIO  = 4'h2;

    // register offset field inside a region
    localparam int OFS_W = 8;

    // timer registers
    localparam logic [OFS_W-1:0] TIMER_CTRL  = 8'h00;
    localparam logic [OFS_W-1:0] TIMER_VALUE = 8'h04;
    localparam logic [OFS_W-1:0] TIMER_CMP   = 8'h08;

    // timer control bits
    localparam int TMR_EN_BIT   = 0;
    localparam int TMR_IE_BIT   = 1;
    localparam int TMR_PEND_BIT = 2;

    // gpio registers
    localparam logic [OFS_W-1:0] GPIO_CTRL = 8'h00;
    localparam logic [OFS_W-1:0] GPIO_DATA = 8'h04;

    // per-pin mode field, other codes leave the pin off
    localparam logic [1:0] GPIO_MODE_OUT = 2'b01;
    localparam logic [1:0] GPIO_MODE_IN  = 2'b10;

endpackage

`default_nettype wire

// File: source/periph_bus_if.sv
// register bus connection between a master and a slave, one word wide
`default_nettype none
`timescale 1ns/100ps

interface periph_bus_if;
    import rooth_pkg::*;

    logic [CPU_WIDTH-1:0] addr;
    logic [CPU_WIDTH-1:0] wdata;
    logic [CPU_WIDTH-1:0] rdata;
    // on the slave side req means selected this cycle
    logic                 req;
    logic                 we;

    modport master (
        output addr,
        output wdata,
        output req,
        output we,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  req,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

// File: source/rib.sv
// rib interconnect, two masters with fixed priority onto three decoded slaves
`default_nettype none
`timescale 1ns/100ps

module rib (
    input  wire          clk,
    input  wire          arst_n_i,
    periph_bus_if.slave  m0,
    periph_bus_if.slave  m1,
    periph_bus_if.master s_ram,
    periph_bus_if.master s_timer,
    periph_bus_if.master s_gpio,
    output logic         hold_o
);
    import rooth_pkg::*;

    logic                 any_req;
    logic                 grant_q;
    logic                 sel_m1;
    logic [CPU_WIDTH-1:0] addr_mux;
    logic [CPU_WIDTH-1:0] wdata_mux;
    logic                 we_mux;
    logic [SLV_SEL_W-1:0] slv_sel;
    logic                 hit_ram;
    logic                 hit_timer;
    logic                 hit_gpio;
    logic [CPU_WIDTH-1:0] slv_rdata;

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    assign any_req = m0.req | m1.req;

    // last owner, keeps the bus parked while idle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= 1'b0;
        end else if (any_req) begin
            grant_q <= m1.req;
        end
    end

    // debug port wins, idle cycles stay on the last owner
    assign sel_m1 = m1.req | (~m0.req & grant_q);

    // core is stalled whenever debug takes the bus
    assign hold_o = m1.req;

    assign addr_mux  = sel_m1 ? m1.addr : m0.addr;
    assign wdata_mux = sel_m1 ? m1.wdata : m0.wdata;
    assign we_mux    = sel_m1 ? m1.we : m0.we;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign slv_sel   = addr_mux[CPU_WIDTH-1 -: SLV_SEL_W];
    assign hit_ram   = (slv_sel == SLV_RAM);
    assign hit_timer = (slv_sel == SLV_TIMER);
    assign hit_gpio  = (slv_sel == SLV_GPIO);

    // only the decoded slave sees the access
    assign s_ram.req   = any_req & hit_ram;
    assign s_ram.we    = any_req & hit_ram & we_mux;
    assign s_ram.addr  = hit_ram ? addr_mux : '0;
    assign s_ram.wdata = hit_ram ? wdata_mux : '0;

    assign s_timer.req   = any_req & hit_timer;
    assign s_timer.we    = any_req & hit_timer & we_mux;
    assign s_timer.addr  = hit_timer ? addr_mux : '0;
    assign s_timer.wdata = hit_timer ? wdata_mux : '0;

    assign s_gpio.req   = any_req & hit_gpio;
    assign s_gpio.we    = any_req & hit_gpio & we_mux;
    assign s_gpio.addr  = hit_gpio ? addr_mux : '0;
    assign s_gpio.wdata = hit_gpio ? wdata_mux : '0;

    // ----------------------------------------
    // read return
    // ----------------------------------------
    always_comb begin
        case (slv_sel)
            SLV_RAM:   slv_rdata = s_ram.rdata;
            SLV_TIMER: slv_rdata = s_timer.rdata;
            SLV_GPIO:  slv_rdata = s_gpio.rdata;
            // unmapped reads 0
            default:   slv_rdata = '0;
        endcase
    end

    // losing master gets 0
    assign m1.rdata = m1.req ? slv_rdata : '0;
    assign m0.rdata = (m0.req & ~m1.req) ? slv_rdata : '0;

endmodule

`default_nettype wire

// File: source/data_ram.sv
// data RAM, word addressed, write on the clock edge and combinational read
`default_nettype none
`timescale 1ns/100ps

module data_ram #(
    parameter int RAM_AW = 8
) (
    input  wire         clk,
    input  wire         arst_n_i,
    periph_bus_if.slave bus
);
    import rooth_pkg::*;

    localparam int DEPTH = 1 << RAM_AW;

    logic [CPU_WIDTH-1:0] mem [DEPTH];
    logic [RAM_AW-1:0]    word_idx;
    logic                 wr_en;

    // byte address to word index
    assign word_idx = bus.addr[RAM_AW+1:2];

    // writes are blocked while reset is held
    assign wr_en = arst_n_i & bus.req & bus.we;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= bus.wdata;
        end
    end

    assign bus.rdata = mem[word_idx];

endmodule

`default_nettype wire

// File: source/timer.sv
// timer with compare reload, pending flag and registered interrupt
`default_nettype none
`timescale 1ns/100ps

module timer (
    input  wire         clk,
    input  wire         arst_n_i,
    periph_bus_if.slave bus,
    output logic        int_o
);
    import rooth_pkg::*;

    logic                 en_q;
    logic                 ie_q;
    logic                 pend_q;
    logic [CPU_WIDTH-1:0] value_q;
    logic [CPU_WIDTH-1:0] cmp_q;
    logic [OFS_W-1:0]     ofs;
    logic                 wr;
    logic                 ctrl_wr;
    logic                 value_wr;
    logic                 cmp_wr;
    logic                 pend_clr;
    logic                 match;

    // ----------------------------------------
    // register decode
    // ----------------------------------------
    assign ofs      = bus.addr[OFS_W-1:0];
    assign wr       = bus.req & bus.we;
    assign ctrl_wr  = wr & (ofs == TIMER_CTRL);
    assign value_wr = wr & (ofs == TIMER_VALUE);
    assign cmp_wr   = wr & (ofs == TIMER_CMP);
    // pending is write-one-to-clear
    assign pend_clr = ctrl_wr & bus.wdata[TMR_PEND_BIT];

    assign match = en_q & (value_q == cmp_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q    <= 1'b0;
            ie_q    <= 1'b0;
            pend_q  <= 1'b0;
            cmp_q   <= '0;
            value_q <= '0;
            int_o   <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                en_q <= bus.wdata[TMR_EN_BIT];
                ie_q <= bus.wdata[TMR_IE_BIT];
            end
            if (cmp_wr) begin
                cmp_q <= bus.wdata;
            end
            // bus load wins over counting
            if (value_wr) begin
                value_q <= bus.wdata;
            end else if (match) begin
                value_q <= '0;
            end else if (en_q) begin
                value_q <= value_q + 1'b1;
            end
            // a new match beats a clear in the same cycle
            pend_q <= (pend_q & ~pend_clr) | match;
            int_o  <= pend_q & ie_q;
        end
    end

    // ----------------------------------------
    // read back
    // ----------------------------------------
    always_comb begin
        bus.rdata = '0;
        case (ofs)
            TIMER_CTRL: begin
                bus.rdata[TMR_EN_BIT]   = en_q;
                bus.rdata[TMR_IE_BIT]   = ie_q;
                bus.rdata[TMR_PEND_BIT] = pend_q;
            end
            TIMER_VALUE: bus.rdata = value_q;
            TIMER_CMP:   bus.rdata = cmp_q;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/gpio.sv
// GPIO block with 2-bit pin modes, data register and sampled pin inputs
`default_nettype none
`timescale 1ns/100ps

module gpio #(
    parameter int GPIO_NUM = 16
) (
    input  wire                 clk,
    input  wire                 arst_n_i,
    periph_bus_if.slave         bus,
    input  wire  [GPIO_NUM-1:0] pin_i,
    output logic [GPIO_NUM-1:0] pin_o,
    output logic [GPIO_NUM-1:0] pin_oe_o
);
    import rooth_pkg::*;

    logic [2*GPIO_NUM-1:0] mode_q;
    logic [GPIO_NUM-1:0]   data_q;
    logic [GPIO_NUM-1:0]   pin_q;
    logic [GPIO_NUM-1:0]   data_rd;
    logic [OFS_W-1:0]      ofs;
    logic                  wr;

    assign ofs = bus.addr[OFS_W-1:0];
    assign wr  = bus.req & bus.we;

    // ----------------------------------------
    // registers and pin sampling
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode_q <= '0;
            data_q <= '0;
            pin_q  <= '0;
        end else begin
            if (wr && ofs == GPIO_CTRL) begin
                mode_q <= bus.wdata[2*GPIO_NUM-1:0];
            end
            if (wr && ofs == GPIO_DATA) begin
                data_q <= bus.wdata[GPIO_NUM-1:0];
            end
            // one flop on the pads
            pin_q <= pin_i;
        end
    end

    // per-pin drive and read select
    always_comb begin
        for (int i = 0; i < GPIO_NUM; i++) begin
            pin_oe_o[i] = (mode_q[2*i +: 2] == GPIO_MODE_OUT);
            data_rd[i]  = (mode_q[2*i +: 2] == GPIO_MODE_IN) ? pin_q[i] : data_q[i];
        end
    end

    assign pin_o = data_q;

    always_comb begin
        bus.rdata = '0;
        case (ofs)
            GPIO_CTRL: bus.rdata[2*GPIO_NUM-1:0] = mode_q;
            GPIO_DATA: bus.rdata[GPIO_NUM-1:0]   = data_rd;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rooth_bus_top.sv
// rooth bus top level with two masters, the rib interconnect and three slaves
`default_nettype none
`timescale 1ns/100ps

module rooth_bus_top #(
    parameter int RAM_AW   = 8,
    parameter int GPIO_NUM = 16
) (
    input  wire                             clk,
    input  wire                             arst_n_i,
    // core data port
    input  wire                             m0_req_i,
    input  wire                             m0_we_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0] m0_addr_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0] m0_wdata_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0] m0_rdata_o,
    // debug memory port
    input  wire                             m1_req_i,
    input  wire                             m1_we_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0] m1_addr_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0] m1_wdata_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0] m1_rdata_o,
    output logic                            hold_o,
    output logic                            timer_int_o,
    input  wire  [GPIO_NUM-1:0]             gpio_i,
    output logic [GPIO_NUM-1:0]             gpio_o,
    output logic [GPIO_NUM-1:0]             gpio_oe_o
);

    periph_bus_if bus_m0 ();
    periph_bus_if bus_m1 ();
    periph_bus_if bus_ram ();
    periph_bus_if bus_timer ();
    periph_bus_if bus_gpio ();

    // ----------------------------------------
    // master ports into the bus
    // ----------------------------------------
    assign bus_m0.req   = m0_req_i;
    assign bus_m0.we    = m0_we_i;
    assign bus_m0.addr  = m0_addr_i;
    assign bus_m0.wdata = m0_wdata_i;
    assign m0_rdata_o   = bus_m0.rdata;

    assign bus_m1.req   = m1_req_i;
    assign bus_m1.we    = m1_we_i;
    assign bus_m1.addr  = m1_addr_i;
    assign bus_m1.wdata = m1_wdata_i;
    assign m1_rdata_o   = bus_m1.rdata;

    rib u_rib (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .m0       (bus_m0.slave),
        .m1       (bus_m1.slave),
        .s_ram    (bus_ram.master),
        .s_timer  (bus_timer.master),
        .s_gpio   (bus_gpio.master),
        .hold_o   (hold_o)
    );

    // ----------------------------------------
    // slaves
    // ----------------------------------------
    data_ram #(
        .RAM_AW (RAM_AW)
    ) u_data_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus_ram.slave)
    );

    timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus_timer.slave),
        .int_o    (timer_int_o)
    );

    gpio #(
        .GPIO_NUM (GPIO_NUM)
    ) u_gpio (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus_gpio.slave),
        .pin_i    (gpio_i),
        .pin_o    (gpio_o),
        .pin_oe_o (gpio_oe_o)
    );

endmodule

`default_nettype wire

// File: dv/rooth_bus_tb.sv
// rooth bus testbench, random traffic from both masters checked against a model
`default_nettype none
`timescale 1ns/100ps

module rooth_bus_tb;
    import rooth_pkg::*;

    localparam int RAM_AW     = 8;
    localparam int GPIO_NUM   = 16;
    localparam int N_FILL     = 1 << RAM_AW;
    localparam int N_RAND     = 400;
    localparam int N_REG_RD   = 5;
    localparam int N_TIMER    = 80;
    localparam int N_GPIO     = 8;
    localparam int TOTAL_CYC  = 3 + N_FILL + N_RAND + N_REG_RD + N_TIMER + N_GPIO * 8;
    localparam int TIMEOUT_NS = TOTAL_CYC * 10 + 2000;

    localparam logic [31:0] A_TMR_CTRL  = {SLV_TIMER, 20'h0, TIMER_CTRL};
    localparam logic [31:0] A_TMR_VALUE = {SLV_TIMER, 20'h0, TIMER_VALUE};
    localparam logic [31:0] A_TMR_CMP   = {SLV_TIMER, 20'h0, TIMER_CMP};
    localparam logic [31:0] A_GPIO_CTRL = {SLV_GPIO, 20'h0, GPIO_CTRL};
    localparam logic [31:0] A_GPIO_DATA = {SLV_GPIO, 20'h0, GPIO_DATA};

    logic                 clk;
    logic                 arst_n_i;
    logic                 m0_req_i;
    logic                 m0_we_i;
    logic [CPU_WIDTH-1:0] m0_addr_i;
    logic [CPU_WIDTH-1:0] m0_wdata_i;
    logic [CPU_WIDTH-1:0] m0_rdata_o;
    logic                 m1_req_i;
    logic                 m1_we_i;
    logic [CPU_WIDTH-1:0] m1_addr_i;
    logic [CPU_WIDTH-1:0] m1_wdata_i;
    logic [CPU_WIDTH-1:0] m1_rdata_o;
    logic                 hold_o;
    logic                 timer_int_o;
    logic [GPIO_NUM-1:0]  gpio_i;
    logic [GPIO_NUM-1:0]  gpio_o;
    logic [GPIO_NUM-1:0]  gpio_oe_o;

    logic [CPU_WIDTH-1:0] ram_m [N_FILL];
    logic [31:0]          lfsr_state;
    int                   mismatch_cnt;
    int                   fail_cnt;

    rooth_bus_top #(.RAM_AW(RAM_AW), .GPIO_NUM(GPIO_NUM)) u_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------
    // random source and RAM model
    // ----------------------------------------
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] word_addr(input logic [3:0] nib, input int idx);
        return {nib, {(CPU_WIDTH-6-RAM_AW){1'b0}}, idx[RAM_AW-1:0], 2'b00};
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        // unmapped regions read 0
        return (a[31:28] == SLV_RAM) ? ram_m[a[RAM_AW+1:2]] : '0;
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d);
        if (a[31:28] == SLV_RAM) begin
            ram_m[a[RAM_AW+1:2]] = d;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ----------------------------------------
    // bus cycles
    // ----------------------------------------
    task automatic bus_cycle(input logic r0, input logic w0, input logic [31:0] a0,
                             input logic [31:0] d0, input logic r1, input logic w1,
                             input logic [31:0] a1, input logic [31:0] d1);
        @(posedge clk);
        m0_req_i   <= r0;
        m0_we_i    <= w0;
        m0_addr_i  <= a0;
        m0_wdata_i <= d0;
        m1_req_i   <= r1;
        m1_we_i    <= w1;
        m1_addr_i  <= a1;
        m1_wdata_i <= d1;
        @(negedge clk);
    endtask

    task automatic bus_idle();
        bus_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
        bus_cycle(1'b1, 1'b1, a, d, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic read_reg(input logic [31:0] a, output logic [31:0] d);
        bus_cycle(1'b1, 1'b0, a, '0, 1'b0, 1'b0, '0, '0);
        d = m0_rdata_o;
    endtask

    task automatic gen_access(output logic we, output logic [31:0] addr,
                              output logic [31:0] data);
        logic [31:0] sel;
        logic [31:0] hi;
        logic [31:0] wbit;
        logic [3:0]  nib;
        sel = take_bits(3);
        nib = SLV_RAM;
        // about one access in eight goes to an unmapped region
        if (sel[2:0] == 3'd0) begin
            hi  = take_bits(3);
            nib = {1'b1, hi[2:0]};
        end
        addr = word_addr(nib, int'(take_bits(RAM_AW)));
        wbit = take_bits(1);
        we   = wbit[0];
        data = take_bits(32);
    endtask

    // ----------------------------------------
    // test phases
    // ----------------------------------------
    task automatic fill_ram();
        logic [31:0] d;
        for (int i = 0; i < N_FILL; i++) begin
            d = (32'(i) * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
            if (i % 2 == 1) begin
                bus_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, word_addr(SLV_RAM, i), d);
            end else begin
                bus_cycle(1'b1, 1'b1, word_addr(SLV_RAM, i), d, 1'b0, 1'b0, '0, '0);
            end
            ram_m[i] = d;
        end
    endtask

    task automatic run_random();
        logic        p0_valid;
        logic        p0_we;
        logic [31:0] p0_addr;
        logic [31:0] p0_data;
        logic        w1;
        logic [31:0] a1;
        logic [31:0] d1;
        logic [31:0] pick;
        p0_valid = 1'b0;
        for (int step = 0; step < N_RAND; step++) begin
            if (!p0_valid) begin
                gen_access(p0_we, p0_addr, p0_data);
                p0_valid = 1'b1;
            end
            pick = take_bits(2);
            w1 = 1'b0;
            a1 = '0;
            d1 = '0;
            if (pick[1:0] == 2'b11) begin
                gen_access(w1, a1, d1);
            end
            bus_cycle(1'b1, p0_we, p0_addr, p0_data, pick[1:0] == 2'b11, w1, a1, d1);
            if (pick[1:0] == 2'b11) begin
                // core was held, its access stays pending
                if (w1) model_write(a1, d1);
                else check_val("m1_rdata_o", m1_rdata_o, model_read(a1));
            end else begin
                if (p0_we) model_write(p0_addr, p0_data);
                else check_val("m0_rdata_o", m0_rdata_o, model_read(p0_addr));
                p0_valid = 1'b0;
            end
        end
    endtask

    // unmapped writes must not have reached any register
    task automatic expect_regs_zero();
        logic [31:0] rd;
        read_reg(A_TMR_CTRL, rd);
        check_val("timer ctrl", rd, '0);
        read_reg(A_TMR_VALUE, rd);
        check_val("timer value", rd, '0);
        read_reg(A_TMR_CMP, rd);
        check_val("timer cmp", rd, '0);
        read_reg(A_GPIO_CTRL, rd);
        check_val("gpio ctrl", rd, '0);
        read_reg(A_GPIO_DATA, rd);
        check_val("gpio data", rd, '0);
        check_val("gpio_oe_o", 32'(gpio_oe_o), '0);
        check_val("timer_int_o", 32'(timer_int_o), '0);
    endtask

    task automatic wait_int(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (timer_int_o !== level && n < max_cycles) begin
            bus_idle();
            n++;
        end
        assert (timer_int_o === level) else begin
            fail_cnt++;
            $display("timer_int_o did not go to %0d within %0d cycles", level, max_cycles);
        end
    endtask

    task automatic run_timer();
        logic [31:0] cmp;
        logic [31:0] rd;
        cmp = 32'd3 + take_bits(4);
        write_reg(A_TMR_CMP, cmp);
        write_reg(A_TMR_VALUE, '0);
        read_reg(A_TMR_CMP, rd);
        check_val("timer cmp", rd, cmp);
        write_reg(A_TMR_CTRL, 32'h3);
        wait_int(1'b1, int'(cmp) + 3);
        // stop counting so no new match races the clear
        write_reg(A_TMR_CTRL, 32'h2);
        write_reg(A_TMR_CTRL, 32'h6);
        wait_int(1'b0, 2);
        read_reg(A_TMR_CTRL, rd);
        check_val("timer ctrl", rd, 32'h2);
        // count again with the interrupt masked
        write_reg(A_TMR_CTRL, 32'h1);
        for (int i = 0; i < int'(cmp) + 3; i++) begin
            bus_idle();
            check_val("timer_int_o", 32'(timer_int_o), 32'h0);
        end
        read_reg(A_TMR_CTRL, rd);
        check_val("timer ctrl", rd, 32'h5);
        write_reg(A_TMR_CTRL, 32'h0);
        write_reg(A_TMR_CTRL, 32'h4);
    endtask

    task automatic run_gpio();
        logic [31:0]         mode;
        logic [31:0]         data;
        logic [31:0]         pins;
        logic [31:0]         rd;
        logic [GPIO_NUM-1:0] exp_oe;
        logic [GPIO_NUM-1:0] exp_rd;
        logic [1:0]          fld;
        for (int n = 0; n < N_GPIO; n++) begin
            mode = take_bits(2 * GPIO_NUM);
            data = take_bits(GPIO_NUM);
            pins = take_bits(GPIO_NUM);
            for (int i = 0; i < GPIO_NUM; i++) begin
                fld       = mode[2*i +: 2];
                exp_oe[i] = (fld == 2'b01);
                exp_rd[i] = (fld == 2'b10) ? pins[i] : data[i];
            end
            write_reg(A_GPIO_CTRL, mode);
            write_reg(A_GPIO_DATA, data);
            @(posedge clk);
            gpio_i   <= pins[GPIO_NUM-1:0];
            m0_req_i <= 1'b0;
            @(negedge clk);
            bus_idle();
            check_val("gpio_oe_o", 32'(gpio_oe_o), 32'(exp_oe));
            check_val("gpio_o", 32'(gpio_o), data);
            read_reg(A_GPIO_DATA, rd);
            check_val("gpio data", rd, 32'(exp_rd));
            read_reg(A_GPIO_CTRL, rd);
            check_val("gpio ctrl", rd, mode);
        end
    endtask

    // ----------------------------------------
    // arbitration monitor, every cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (arst_n_i) begin
            check_val("hold_o", 32'(hold_o), 32'(m1_req_i));
            if (m1_req_i || !m0_req_i) check_val("m0_rdata_o", m0_rdata_o, '0);
            if (!m1_req_i) check_val("m1_rdata_o", m1_rdata_o, '0);
        end
    end

    initial begin
        mismatch_cnt = 0;
        fail_cnt     = 0;
        lfsr_state   = 32'h96d2;
        arst_n_i     = 1'b0;
        m0_req_i     = 1'b0;
        m0_we_i      = 1'b0;
        m0_addr_i    = '0;
        m0_wdata_i   = '0;
        m1_req_i     = 1'b0;
        m1_we_i      = 1'b0;
        m1_addr_i    = '0;
        m1_wdata_i   = '0;
        gpio_i       = '0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        fill_ram();
        run_random();
        expect_regs_zero();
        run_timer();
        run_gpio();
        bus_idle();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rooth_bus.f
source/rooth_pkg.sv
source/periph_bus_if.sv
source/rib.sv
source/data_ram.sv
source/timer.sv
source/gpio.sv
source/rooth_bus_top.sv
dv/rooth_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rooth bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module rooth_bus_tb \
    -f rooth_bus.f

./obj_dir/Vrooth_bus_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
